// File: bench/renamer_assertions.sv
/*
  Concurrent checks on the renamer top level.
  Bound to register_renamer from the testbench.
*/
`timescale 1ns/1ps

module renamer_assertions
    import rename_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input arch_reg_t decode_rd_addr,
    input arch_reg_t decode_rs1_addr,
    input arch_reg_t decode_rs2_addr,
    input phys_reg_t phys_rd,
    input phys_reg_t phys_rs1,
    input phys_reg_t phys_rs2,
    input logic      rename_ready
);

    // x0 as destination never takes a register
    rd_zero_chk: assert property (@(posedge clk) disable iff (rst)
        (decode_rd_addr == '0) |-> (phys_rd == '0))
        else $error("phys_rd is nonzero for destination x0");

    // x0 stays on physical register 0 once start-up is over
    rs1_zero_chk: assert property (@(posedge clk) disable iff (rst)
        (rename_ready && decode_rs1_addr == '0) |-> (phys_rs1 == '0))
        else $error("source x0 on rs1 maps to a nonzero register");

    rs2_zero_chk: assert property (@(posedge clk) disable iff (rst)
        (rename_ready && decode_rs2_addr == '0) |-> (phys_rs2 == '0))
        else $error("source x0 on rs2 maps to a nonzero register");

    // Start-up pass holds off renames right after reset
    ready_after_rst_chk: assert property (@(posedge clk)
        rst |=> !rename_ready)
        else $error("rename_ready high in the cycle after reset");

endmodule

// File: bench/renamer_tb.sv
/*
  Directed testbench for the register renaming unit. A reference model of
  the map, the free list and the per-id history predicts every lookup.
  Inputs change on the falling edge, outputs are checked 1 ns later.
*/
`timescale 1ns/1ps
`include "rename_consts.svh"

module renamer_tb
    import rename_pkg::*;
();

    logic      clk;
    logic      rst;
    logic      decode_advance;
    logic      decode_uses_rd;
    arch_reg_t decode_rd_addr;
    arch_reg_t decode_rs1_addr;
    arch_reg_t decode_rs2_addr;
    inst_id_t  decode_id;
    wb_group_t decode_rd_wb_group;
    phys_reg_t phys_rs1;
    phys_reg_t phys_rs2;
    wb_group_t rs1_wb_group;
    wb_group_t rs2_wb_group;
    phys_reg_t phys_rd;
    logic      rename_ready;
    logic      issue_valid;
    logic      issue_uses_rd;
    arch_reg_t issue_rd_addr;
    logic      flush;
    logic      retire_valid;
    inst_id_t  retire_id;
    logic      retire_float;
    logic      suppress_writeback;

    // Reference model
    phys_reg_t map_phys     [`RN_ARCH_REGS];
    wb_group_t map_grp      [`RN_ARCH_REGS];
    phys_reg_t free_q       [$];
    phys_reg_t hist_old     [`RN_NUM_IDS];
    wb_group_t hist_old_grp [`RN_NUM_IDS];
    phys_reg_t hist_new     [`RN_NUM_IDS];
    arch_reg_t hist_rd      [`RN_NUM_IDS];

    integer seed = 20479;
    int     errors = 0;
    int     checks = 0;

    register_renamer i_dut (.*);

    bind register_renamer renamer_assertions i_checks (
        .clk             (clk),
        .rst             (rst),
        .decode_rd_addr  (decode_rd_addr),
        .decode_rs1_addr (decode_rs1_addr),
        .decode_rs2_addr (decode_rs2_addr),
        .phys_rd         (phys_rd),
        .phys_rs1        (phys_rs1),
        .phys_rs2        (phys_rs2),
        .rename_ready    (rename_ready)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////
    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR time=%0t %s got=%0d exp=%0d", $time, name, got, exp);
            errors++;
        end
    endtask

    // Nonzero destination, never x0
    function automatic arch_reg_t rand_rd();
        logic [31:0] r;
        r = $random(seed);
        return arch_reg_t'(r % 31 + 1);
    endfunction

    // Called on a falling edge
    task automatic wait_ready();
        int n;
        n = 0;
        while (!rename_ready && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!rename_ready) begin
            $display("Timeout: rename_ready stayed low for 100 cycles");
            errors++;
        end
    endtask

    // Sources and destination all point at src, rs2 at its complement
    task automatic check_lookup(input arch_reg_t src);
        phys_reg_t exp_rd;
        decode_rs1_addr = src;
        decode_rs2_addr = ~src;
        decode_rd_addr  = src;
        exp_rd = (src != '0) ? free_q[0] : '0;
        #1;
        check_eq("phys_rs1", 32'(phys_rs1), 32'(map_phys[src]));
        check_eq("rs1_wb_group", 32'(rs1_wb_group), 32'(map_grp[src]));
        check_eq("phys_rs2", 32'(phys_rs2), 32'(map_phys[~src]));
        check_eq("rs2_wb_group", 32'(rs2_wb_group), 32'(map_grp[~src]));
        check_eq("phys_rd", 32'(phys_rd), 32'(exp_rd));
        @(negedge clk);
    endtask

    task automatic rename_one(input arch_reg_t rd, input logic uses,
                              input inst_id_t id, input wb_group_t grp);
        phys_reg_t exp_rd;
        wait_ready();
        decode_advance     = 1'b1;
        decode_uses_rd     = uses;
        decode_rd_addr     = rd;
        decode_id          = id;
        decode_rd_wb_group = grp;
        exp_rd = (rd != '0) ? free_q[0] : '0;
        #1;
        check_eq("phys_rd", 32'(phys_rd), 32'(exp_rd));
        @(negedge clk);
        decode_advance = 1'b0;
        decode_uses_rd = 1'b0;
        // Only a real destination pops a register and records history
        if (uses && rd != '0) begin
            hist_old[id]     = map_phys[rd];
            hist_old_grp[id] = map_grp[rd];
            hist_new[id]     = free_q.pop_front();
            hist_rd[id]      = rd;
            map_phys[rd]     = hist_new[id];
            map_grp[rd]      = grp;
        end
    endtask

    task automatic retire_one(input inst_id_t id, input logic is_float,
                              input logic sup);
        retire_valid       = 1'b1;
        retire_id          = id;
        retire_float       = is_float;
        suppress_writeback = sup;
        @(negedge clk);
        retire_valid       = 1'b0;
        retire_float       = 1'b0;
        suppress_writeback = 1'b0;
        // Float retires hold no integer register
        if (!is_float) begin
            if (sup) begin
                map_phys[hist_rd[id]] = hist_old[id];
                map_grp[hist_rd[id]]  = hist_old_grp[id];
                free_q.push_back(hist_new[id]);
            end else begin
                free_q.push_back(hist_old[id]);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////
    task automatic test_startup();
        int cycles;
        // Identity map, upper half free in order
        for (int i = 0; i < `RN_ARCH_REGS; i++) begin
            map_phys[i] = phys_reg_t'(i);
            map_grp[i]  = '0;
            free_q.push_back(phys_reg_t'(i + `RN_ARCH_REGS));
        end
        cycles = 0;
        while (!rename_ready && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (rename_ready) begin
            check_eq("rename_ready rise cycle", 32'(cycles), 32);
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                check_lookup(arch_reg_t'(i));
            end
        end else begin
            $display("Timeout: start-up pass did not end within 100 cycles");
            errors++;
        end
    endtask

    task automatic test_rename();
        arch_reg_t rd;
        for (int i = 0; i < 6; i++) begin
            rd = rand_rd();
            rename_one(rd, 1'b1, inst_id_t'(i), wb_group_t'($random(seed)));
            check_lookup(rd);
        end
        // x0 and no-rd instructions leave the head in place
        rename_one('0, 1'b1, 3'd6, '0);
        rename_one(5'd7, 1'b0, 3'd7, '0);
        check_lookup(5'd7);
    endtask

    task automatic test_rollback();
        arch_reg_t rd;
        phys_reg_t taken;
        rd    = rand_rd();
        taken = free_q[0];
        rename_one(rd, 1'b1, 3'd6, '1);
        // Flush hits the instruction just renamed, now in issue
        flush         = 1'b1;
        issue_valid   = 1'b1;
        issue_uses_rd = 1'b1;
        issue_rd_addr = rd;
        @(negedge clk);
        flush         = 1'b0;
        issue_valid   = 1'b0;
        issue_uses_rd = 1'b0;
        map_phys[rd]  = hist_old[6];
        map_grp[rd]   = hist_old_grp[6];
        free_q.push_front(taken);
        check_lookup(rd);
    endtask

    task automatic test_retire();
        for (int i = 0; i < 4; i++) begin
            retire_one(inst_id_t'(i), 1'b0, 1'b0);
        end
        retire_one(3'd4, 1'b1, 1'b0);
        // Mappings untouched by a normal retire
        check_lookup(hist_rd[0]);
        check_lookup(hist_rd[3]);
    endtask

    task automatic test_suppress();
        arch_reg_t rd;
        phys_reg_t prev;
        rd   = rand_rd();
        prev = map_phys[rd];
        rename_one(rd, 1'b1, 3'd5, '0);
        retire_one(3'd5, 1'b0, 1'b1);
        check_lookup(rd);
        check_eq("phys_rs1", 32'(phys_rs1), 32'(prev));
    endtask

    // Freed registers come up as heads while draining
    task automatic test_empty();
        inst_id_t id;
        id = '0;
        while (free_q.size() > 0) begin
            check_eq("rename_ready", 32'(rename_ready), 1);
            rename_one(rand_rd(), 1'b1, id, wb_group_t'($random(seed)));
            id = inst_id_t'(id + 1);
        end
        check_eq("rename_ready", 32'(rename_ready), 0);
        id = inst_id_t'(id - 1);
        retire_one(id, 1'b0, 1'b0);
        check_eq("rename_ready", 32'(rename_ready), 1);
        check_lookup(hist_rd[id]);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////
    initial begin
        rst                = 1'b1;
        decode_advance     = 1'b0;
        decode_uses_rd     = 1'b0;
        decode_rd_addr     = '0;
        decode_rs1_addr    = '0;
        decode_rs2_addr    = '0;
        decode_id          = '0;
        decode_rd_wb_group = '0;
        issue_valid        = 1'b0;
        issue_uses_rd      = 1'b0;
        issue_rd_addr      = '0;
        flush              = 1'b0;
        retire_valid       = 1'b0;
        retire_id          = '0;
        retire_float       = 1'b0;
        suppress_writeback = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        test_startup();
        test_rename();
        test_rollback();
        test_retire();
        test_suppress();
        test_empty();
        finish_run();
    end

endmodule

// File: build.f
+incdir+source
source/rename_pkg.sv
source/rename_ctrl.sv
source/phys_free_list.sv
source/spec_map_table.sv
source/id_history_table.sv
source/register_renamer.sv
bench/renamer_assertions.sv
bench/renamer_tb.sv

// File: run.sh
#!/bin/sh
# Builds the renamer testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -f build.f --top-module renamer_tb &&
./obj_dir/Vrenamer_tb | tee /dev/stderr | grep -q -F "TESTS PASSED" &&
echo "Renamer simulation passed" ||
{ echo "Renamer simulation did not pass"; exit 1; }

// File: source/id_history_table.sv
/*
  Per-instruction history of each rename: old mapping, new register
  and destination. Written at rename, read by the retiring id.
*/
`timescale 1ns/1ps
`include "rename_consts.svh"

module id_history_table
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      we,
    input  inst_id_t  wr_id,
    input  phys_reg_t old_phys,
    input  wb_group_t old_group,
    input  phys_reg_t new_phys,
    input  arch_reg_t rd,
    input  inst_id_t  rd_id,
    output phys_reg_t hist_old_phys,
    output wb_group_t hist_old_group,
    output phys_reg_t hist_new_phys,
    output arch_reg_t hist_rd
);

    // One record per id
    phys_reg_t old_phys_mem  [`RN_NUM_IDS];
    wb_group_t old_group_mem [`RN_NUM_IDS];
    phys_reg_t new_phys_mem  [`RN_NUM_IDS];
    arch_reg_t rd_mem        [`RN_NUM_IDS];

    always_ff @(posedge clk) begin
        if (we) begin
            old_phys_mem[wr_id]  <= old_phys;
            old_group_mem[wr_id] <= old_group;
            new_phys_mem[wr_id]  <= new_phys;
            rd_mem[wr_id]        <= rd;
        end
    end

    // Retire side read
    assign hist_old_phys  = old_phys_mem[rd_id];
    assign hist_old_group = old_group_mem[rd_id];
    assign hist_new_phys  = new_phys_mem[rd_id];
    assign hist_rd        = rd_mem[rd_id];

endmodule

// File: source/phys_free_list.sv
/*
  Free list of physical register numbers as a circular FIFO.
  Head is the next register to hand out; undo takes back the last pop.
*/
`timescale 1ns/1ps
`include "rename_consts.svh"

module phys_free_list
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      pop,
    input  logic      push,
    input  phys_reg_t push_data,
    input  logic      undo,
    output phys_reg_t head,
    output logic      empty
);

    // Never more free registers than the non-architectural ones
    localparam int DEPTH = `RN_PHYS_REGS - `RN_ARCH_REGS;
    localparam int PTR_W = $clog2(DEPTH);

    phys_reg_t        mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;
    logic [PTR_W:0]   count_next;

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pop and undo never coincide, rename is blocked by flush
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end else if (undo) begin
                // Old value still in the slot behind the read pointer
                rd_ptr <= rd_ptr - 1'b1;
            end
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            count <= count_next;
        end
    end

    // Occupancy, push and pop together cancel
    always_comb begin
        count_next = count;
        if (push) begin
            count_next = count_next + 1'b1;
        end
        if (undo) begin
            count_next = count_next + 1'b1;
        end
        if (pop) begin
            count_next = count_next - 1'b1;
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);

endmodule

// File: source/register_renamer.sv
/*
  Register renaming unit, top level. Connects the control to the free
  list, map table and history table and presents the pipeline ports.
*/
`timescale 1ns/1ps

module register_renamer
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // Decode
    input  logic      decode_advance,
    input  logic      decode_uses_rd,
    input  arch_reg_t decode_rd_addr,
    input  arch_reg_t decode_rs1_addr,
    input  arch_reg_t decode_rs2_addr,
    input  inst_id_t  decode_id,
    input  wb_group_t decode_rd_wb_group,
    output phys_reg_t phys_rs1,
    output phys_reg_t phys_rs2,
    output wb_group_t rs1_wb_group,
    output wb_group_t rs2_wb_group,
    output phys_reg_t phys_rd,
    output logic      rename_ready,
    // Issue
    input  logic      issue_valid,
    input  logic      issue_uses_rd,
    input  arch_reg_t issue_rd_addr,
    input  logic      flush,
    // Retire
    input  logic      retire_valid,
    input  inst_id_t  retire_id,
    input  logic      retire_float,
    input  logic      suppress_writeback
);

    phys_reg_t free_head;
    logic      free_empty;
    logic      fl_pop;
    logic      fl_push;
    phys_reg_t fl_push_data;
    logic      fl_undo;
    logic      map_we;
    arch_reg_t map_waddr;
    phys_reg_t map_wphys;
    wb_group_t map_wgroup;
    phys_reg_t old_phys;
    wb_group_t old_group;
    phys_reg_t saved_phys;
    wb_group_t saved_group;
    logic      hist_we;
    phys_reg_t hist_old_phys;
    wb_group_t hist_old_group;
    phys_reg_t hist_new_phys;
    arch_reg_t hist_rd;

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////
    rename_ctrl i_ctrl (
        .clk                (clk),
        .rst                (rst),
        .decode_advance     (decode_advance),
        .decode_uses_rd     (decode_uses_rd),
        .decode_rd_addr     (decode_rd_addr),
        .decode_rd_wb_group (decode_rd_wb_group),
        .flush              (flush),
        .issue_valid        (issue_valid),
        .issue_uses_rd      (issue_uses_rd),
        .issue_rd_addr      (issue_rd_addr),
        .retire_valid       (retire_valid),
        .retire_float       (retire_float),
        .suppress_writeback (suppress_writeback),
        .free_head          (free_head),
        .free_empty         (free_empty),
        .old_phys           (old_phys),
        .old_group          (old_group),
        .saved_phys         (saved_phys),
        .saved_group        (saved_group),
        .hist_old_phys      (hist_old_phys),
        .hist_old_group     (hist_old_group),
        .hist_new_phys      (hist_new_phys),
        .hist_rd            (hist_rd),
        .rename_ready       (rename_ready),
        .fl_pop             (fl_pop),
        .fl_push            (fl_push),
        .fl_push_data       (fl_push_data),
        .fl_undo            (fl_undo),
        .map_we             (map_we),
        .map_waddr          (map_waddr),
        .map_wphys          (map_wphys),
        .map_wgroup         (map_wgroup),
        .hist_we            (hist_we)
    );

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////
    phys_free_list i_free_list (
        .clk       (clk),
        .rst       (rst),
        .pop       (fl_pop),
        .push      (fl_push),
        .push_data (fl_push_data),
        .undo      (fl_undo),
        .head      (free_head),
        .empty     (free_empty)
    );

    // Source addresses go straight to the map table
    spec_map_table i_map (
        .clk         (clk),
        .we          (map_we),
        .waddr       (map_waddr),
        .wphys       (map_wphys),
        .wgroup      (map_wgroup),
        .rs1_addr    (decode_rs1_addr),
        .rs2_addr    (decode_rs2_addr),
        .rs1_phys    (phys_rs1),
        .rs2_phys    (phys_rs2),
        .rs1_group   (rs1_wb_group),
        .rs2_group   (rs2_wb_group),
        .old_phys    (old_phys),
        .old_group   (old_group),
        .saved_phys  (saved_phys),
        .saved_group (saved_group)
    );

    // History written with the old entry and the head at rename
    id_history_table i_history (
        .clk            (clk),
        .we             (hist_we),
        .wr_id          (decode_id),
        .old_phys       (old_phys),
        .old_group      (old_group),
        .new_phys       (free_head),
        .rd             (decode_rd_addr),
        .rd_id          (retire_id),
        .hist_old_phys  (hist_old_phys),
        .hist_old_group (hist_old_group),
        .hist_new_phys  (hist_new_phys),
        .hist_rd        (hist_rd)
    );

    // x0 never gets a physical register
    assign phys_rd = (decode_rd_addr != '0) ? free_head : '0;

endmodule

// File: source/rename_consts.svh
/*
  Sizing constants for the register renaming unit.
  Included by the package and by any RTL that sizes arrays or counters.
*/

`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// Architectural integer registers x0..x31
`define RN_ARCH_REGS 32

// Physical registers, upper half starts on the free list
`define RN_PHYS_REGS 64

// In-flight instruction ids
`define RN_NUM_IDS 8

// Write-back groups, one tag bit per mapping
`define RN_NUM_WB_GROUPS 2

// Source operands looked up per instruction
`define RN_READ_PORTS 2

`endif

// File: source/rename_ctrl.sv
/*
  Rename control. Runs the start-up pass after reset, decides rename,
  rollback and retire each cycle, and steers the map table write and
  the free list push.
*/
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_ctrl
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      decode_advance,
    input  logic      decode_uses_rd,
    input  arch_reg_t decode_rd_addr,
    input  wb_group_t decode_rd_wb_group,
    input  logic      flush,
    input  logic      issue_valid,
    input  logic      issue_uses_rd,
    input  arch_reg_t issue_rd_addr,
    input  logic      retire_valid,
    input  logic      retire_float,
    input  logic      suppress_writeback,
    input  phys_reg_t free_head,
    input  logic      free_empty,
    input  phys_reg_t old_phys,
    input  wb_group_t old_group,
    input  phys_reg_t saved_phys,
    input  wb_group_t saved_group,
    input  phys_reg_t hist_old_phys,
    input  wb_group_t hist_old_group,
    input  phys_reg_t hist_new_phys,
    input  arch_reg_t hist_rd,
    output logic      rename_ready,
    output logic      fl_pop,
    output logic      fl_push,
    output phys_reg_t fl_push_data,
    output logic      fl_undo,
    output logic      map_we,
    output arch_reg_t map_waddr,
    output phys_reg_t map_wphys,
    output wb_group_t map_wgroup,
    output logic      hist_we
);

    // Top bit of the counter marks the end of the start-up pass
    localparam int CNT_W = $clog2(`RN_ARCH_REGS) + 1;

    logic [CNT_W-1:0] init_count;
    logic             init_active;
    arch_reg_t        init_idx;
    logic             rename_valid;
    logic             rollback;
    logic             retire_int;
    logic             retire_sup;
    logic             map_same;

    //////////////////////////////////////////////////////////////////////
    // Start-up pass, one map entry and one free register per cycle
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            init_count <= '0;
        end else if (init_active) begin
            init_count <= init_count + 1'b1;
        end
    end

    assign init_active = ~init_count[CNT_W-1];
    assign init_idx    = init_count[CNT_W-2:0];

    //////////////////////////////////////////////////////////////////////
    // Per-cycle decisions
    //////////////////////////////////////////////////////////////////////
    // Stalled during start-up or with nothing left to hand out
    assign rename_ready = ~init_active & ~free_empty;

    // x0 and instructions without rd consume nothing
    assign rename_valid = decode_advance & rename_ready & ~flush
                        & decode_uses_rd & (decode_rd_addr != '0);

    // Flushed instruction in issue was the last rename
    assign rollback = flush & issue_valid & issue_uses_rd & (issue_rd_addr != '0);

    // Float retires are accepted but hold no integer register
    assign retire_int = retire_valid & ~retire_float;
    assign retire_sup = retire_int & suppress_writeback;

    //////////////////////////////////////////////////////////////////////
    // Map table write select
    //////////////////////////////////////////////////////////////////////
    // Priority: start-up, suppressed retire, rollback, rename
    // A rename in the same cycle as a suppressed retire loses its write
    always_comb begin
        if (init_active) begin
            // Identity mapping, group 0
            map_waddr  = init_idx;
            map_wphys  = {1'b0, init_idx};
            map_wgroup = '0;
        end else if (retire_sup) begin
            map_waddr  = hist_rd;
            map_wphys  = hist_old_phys;
            map_wgroup = hist_old_group;
        end else if (rollback) begin
            map_waddr  = issue_rd_addr;
            map_wphys  = saved_phys;
            map_wgroup = saved_group;
        end else begin
            map_waddr  = decode_rd_addr;
            map_wphys  = free_head;
            map_wgroup = decode_rd_wb_group;
        end
    end

    // Skip writes that leave the entry as it is
    assign map_same = (old_phys == map_wphys) && (old_group == map_wgroup);
    assign map_we   = init_active | ((retire_sup | rollback | rename_valid) & ~map_same);

    //////////////////////////////////////////////////////////////////////
    // Free list and history
    //////////////////////////////////////////////////////////////////////
    assign fl_pop  = rename_valid;
    assign fl_undo = rollback;
    assign fl_push = init_active | retire_int;

    // Start-up fills with the upper half, retire frees new or old register
    assign fl_push_data = init_active        ? {1'b1, init_idx} :
                          suppress_writeback ? hist_new_phys    : hist_old_phys;

    assign hist_we = rename_valid;

endmodule

// File: source/rename_pkg.sv
/*
  Shared vector types for the register renaming unit.
  Imported by wildcard in every RTL module header.
*/

`include "rename_consts.svh"

package rename_pkg;

    // Architectural register number
    typedef logic [$clog2(`RN_ARCH_REGS)-1:0] arch_reg_t;

    // Physical register number
    typedef logic [$clog2(`RN_PHYS_REGS)-1:0] phys_reg_t;

    // Instruction id, indexes the history table
    typedef logic [$clog2(`RN_NUM_IDS)-1:0] inst_id_t;

    // Write-back group tag carried with each mapping
    typedef logic [$clog2(`RN_NUM_WB_GROUPS)-1:0] wb_group_t;

endpackage

// File: source/spec_map_table.sv
/*
  Speculative map from architectural to physical register.
  One write port, asynchronous reads for the sources and for the entry
  being replaced, which is kept one write back for rollback.
*/
`timescale 1ns/1ps
`include "rename_consts.svh"

module spec_map_table
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      we,
    input  arch_reg_t waddr,
    input  phys_reg_t wphys,
    input  wb_group_t wgroup,
    input  arch_reg_t rs1_addr,
    input  arch_reg_t rs2_addr,
    output phys_reg_t rs1_phys,
    output phys_reg_t rs2_phys,
    output wb_group_t rs1_group,
    output wb_group_t rs2_group,
    output phys_reg_t old_phys,
    output wb_group_t old_group,
    output phys_reg_t saved_phys,
    output wb_group_t saved_group
);

    // Distributed memory, phys number and group side by side
    phys_reg_t phys_mem  [`RN_ARCH_REGS];
    wb_group_t group_mem [`RN_ARCH_REGS];

    arch_reg_t src_addr  [`RN_READ_PORTS];
    phys_reg_t src_phys  [`RN_READ_PORTS];
    wb_group_t src_group [`RN_READ_PORTS];

    always_ff @(posedge clk) begin
        if (we) begin
            phys_mem[waddr]  <= wphys;
            group_mem[waddr] <= wgroup;
            // Entry being overwritten, restored on rollback
            saved_phys       <= old_phys;
            saved_group      <= old_group;
        end
    end

    // Entry at the write index before this cycle's write
    assign old_phys  = phys_mem[waddr];
    assign old_group = group_mem[waddr];

    // Source lookups, no latency
    assign src_addr[0] = rs1_addr;
    assign src_addr[1] = rs2_addr;

    for (genvar i = 0; i < `RN_READ_PORTS; i++) begin : g_src
        assign src_phys[i]  = phys_mem[src_addr[i]];
        assign src_group[i] = group_mem[src_addr[i]];
    end

    assign rs1_phys  = src_phys[0];
    assign rs1_group = src_group[0];
    assign rs2_phys  = src_phys[1];
    assign rs2_group = src_group[1];

endmodule
